/* yolo_cfg.svh */
`ifndef YOLO_CFG_SVH
`define YOLO_CFG_SVH

// operand and result width
`define YOLO_DATA_W 16

// elements per dot product
`define YOLO_ITER_W 8

// results per job
`define YOLO_ITEM_W 10

// fixed-point shift amount
`define YOLO_SHIFT_W 5

// max-pool window length
`define YOLO_POOL_N 4

`endif

/* yolo_pkg.sv */
`default_nettype none
`include "yolo_cfg.svh"

package yolo_pkg;

   // one word of the operand stream
   typedef struct packed {
      logic signed [`YOLO_DATA_W-1:0] a;
      logic signed [`YOLO_DATA_W-1:0] b;
      logic signed [`YOLO_DATA_W-1:0] c;
   } operand_t;

   // job config, sampled on start
   typedef struct packed {
      logic [`YOLO_ITER_W-1:0]  iterations;
      logic [`YOLO_ITEM_W-1:0]  items;
      logic [`YOLO_SHIFT_W-1:0] shift;
      logic                     bias_en;
      logic                     leaky_en;
      logic                     maxpool_en;
      logic                     bypass_en;
   } job_cfg_t;

   // finished dot product on its way to activation
   typedef struct packed {
      logic                             valid;
      logic signed [2*`YOLO_DATA_W-1:0] acc;
      logic signed [`YOLO_DATA_W-1:0]   act;
   } acc_tok_t;

endpackage

`default_nettype wire

/* yolo_iter_cnt.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_iter_cnt (
   input  wire logic                    clk,
   input  wire logic                    rst,
   input  wire logic                    clear,
   input  wire logic                    step,
   input  wire logic [`YOLO_ITER_W-1:0] len,
   input  wire logic [`YOLO_ITEM_W-1:0] items,
   output logic                         first_elem,
   output logic                         last_elem,
   output logic                         last_item
);

   logic [`YOLO_ITER_W-1:0] elem_idx;
   logic [`YOLO_ITEM_W-1:0] item_idx;

   assign first_elem = (elem_idx == '0);
   assign last_elem  = (elem_idx == len - `YOLO_ITER_W'(1));
   assign last_item  = (item_idx == items - `YOLO_ITEM_W'(1));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         elem_idx <= '0;
         item_idx <= '0;
      end else if (clear) begin
         elem_idx <= '0;
         item_idx <= '0;
      end else if (step) begin
         // wrap at end of dot product
         if (last_elem) begin
            elem_idx <= '0;
            item_idx <= item_idx + `YOLO_ITEM_W'(1);
         end else begin
            elem_idx <= elem_idx + `YOLO_ITER_W'(1);
         end
      end
   end

endmodule

`default_nettype wire

/* yolo_ctrl.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_ctrl (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire logic                start,
   input  wire yolo_pkg::job_cfg_t  cfg,
   input  wire logic                in_valid,
   input  wire logic                advance,
   input  wire logic                last_elem,
   input  wire logic                last_item,
   input  wire logic                pipe_busy,
   input  wire logic                out_pending,
   output logic                     in_ready,
   output logic                     accept,
   output logic                     clear,
   output yolo_pkg::job_cfg_t       job,
   output logic                     busy,
   output logic                     done
);

   typedef enum logic [1:0] {IDLE, RUN, DRAIN} state_t;

   state_t             state;
   yolo_pkg::job_cfg_t job_in;

   // in bypass every element is an item of its own
   always_comb begin
      job_in = cfg;
      if (cfg.bypass_en) begin
         job_in.iterations = `YOLO_ITER_W'(1);
      end
   end

   assign in_ready = (state == RUN) && advance;
   assign accept   = in_valid && in_ready;
   assign clear    = (state == IDLE) && start;
   assign busy     = (state != IDLE);
   assign done     = (state == DRAIN) && !pipe_busy && !out_pending;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= IDLE;
         job   <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  job   <= job_in;
                  state <= RUN;
               end
            end
            RUN: begin
               if (accept && last_elem && last_item) begin
                  state <= DRAIN;
               end
            end
            DRAIN: begin
               // pipeline and output empty
               if (done) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

/* yolo_macc.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_macc (
   input  wire logic               clk,
   input  wire logic               rst,
   input  wire logic               advance,
   input  wire logic               accept,
   input  wire logic               first_elem,
   input  wire logic               last_elem,
   input  wire yolo_pkg::operand_t op,
   input  wire yolo_pkg::job_cfg_t job,
   output yolo_pkg::acc_tok_t      tok,
   output logic                    pipe_busy
);

   localparam int DW = `YOLO_DATA_W;

   yolo_pkg::operand_t     s1_op;
   logic                   s1_valid, s1_first, s1_last;
   logic signed [2*DW-1:0] s2_prod, s2_pre;
   logic signed [DW-1:0]   s2_act;
   logic                   s2_valid, s2_first, s2_last;
   logic signed [2*DW-1:0] acc;
   logic signed [DW-1:0]   s3_act;
   logic                   s3_valid;
   logic                   tok_valid;
   logic signed [2*DW-1:0] tok_acc;
   logic signed [DW-1:0]   tok_act;
   logic signed [2*DW-1:0] bias_ext;

   assign bias_ext = {{DW{s1_op.c[DW-1]}}, s1_op.c};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         s3_valid  <= 1'b0;
         tok_valid <= 1'b0;
      end else if (advance) begin
         s1_valid  <= accept;
         s2_valid  <= s1_valid;
         // only a finished sum becomes a token
         s3_valid  <= s2_valid && s2_last;
         tok_valid <= s3_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (advance) begin
         s1_op    <= op;
         s1_first <= first_elem;
         s1_last  <= last_elem;

         s2_prod  <= $signed(s1_op.a) * $signed(s1_op.b);
         s2_pre   <= job.bias_en ? (bias_ext <<< job.shift) : '0;
         s2_act   <= s1_op.a;
         s2_first <= s1_first;
         s2_last  <= s1_last;

         // restart from preload on a new dot product
         if (s2_valid) begin
            acc    <= (s2_first ? s2_pre : acc) + s2_prod;
            s3_act <= s2_act;
         end

         tok_acc <= acc;
         tok_act <= s3_act;
      end
   end

   assign tok       = '{valid: tok_valid, acc: tok_acc, act: tok_act};
   assign pipe_busy = s1_valid || s2_valid || s3_valid || tok_valid;

endmodule

`default_nettype wire

/* yolo_act_pool.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_act_pool (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      advance,
   input  wire yolo_pkg::acc_tok_t        tok,
   input  wire yolo_pkg::job_cfg_t        job,
   output logic                           out_valid,
   input  wire logic                      out_ready,
   output logic signed [`YOLO_DATA_W-1:0] out_data,
   output logic                           out_pending
);

   localparam int DW    = `YOLO_DATA_W;
   localparam int WIN_W = $clog2(`YOLO_POOL_N);

   logic signed [2*DW-1:0] shifted;
   logic signed [DW-1:0]   scaled, act_val, value, pool_val, run_max;
   logic [WIN_W-1:0]       win_cnt;
   logic                   win_last, emit;

   // back to data width
   assign shifted = $signed(tok.acc) >>> job.shift;
   assign scaled  = shifted[DW-1:0];

   // leaky slope of 1/8
   assign act_val = (job.leaky_en && scaled[DW-1]) ? (scaled >>> 3) : scaled;
   assign value   = job.bypass_en ? tok.act : act_val;

   assign pool_val = (win_cnt == '0 || value > run_max) ? value : run_max;
   assign win_last = (win_cnt == WIN_W'(`YOLO_POOL_N - 1));
   assign emit     = advance && tok.valid && (!job.maxpool_en || win_last);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         out_valid <= 1'b0;
         win_cnt   <= '0;
      end else begin
         if (emit) begin
            out_valid <= 1'b1;
         end else if (out_ready) begin
            out_valid <= 1'b0;
         end
         if (advance && tok.valid && job.maxpool_en) begin
            win_cnt <= win_last ? '0 : win_cnt + WIN_W'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (advance && tok.valid) begin
         run_max <= pool_val;
      end
      if (emit) begin
         out_data <= job.maxpool_en ? pool_val : value;
      end
   end

   // a partly filled window still owes a result
   assign out_pending = out_valid || (win_cnt != '0);

endmodule

`default_nettype wire

/* yolo_layer_unit.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_layer_unit (
   input  wire logic                      clk,
   input  wire logic                      rst,
   input  wire logic                      start,
   input  wire yolo_pkg::job_cfg_t        cfg,
   output logic                           busy,
   output logic                           done,
   input  wire logic                      in_valid,
   output logic                           in_ready,
   input  wire yolo_pkg::operand_t        in_data,
   output logic                           out_valid,
   input  wire logic                      out_ready,
   output logic signed [`YOLO_DATA_W-1:0] out_data
);

   logic               advance;
   logic               accept;
   logic               clear;
   logic               first_elem, last_elem, last_item;
   logic               pipe_busy, out_pending;
   yolo_pkg::job_cfg_t job;
   yolo_pkg::acc_tok_t tok;

   // whole pipeline stalls on a held output
   assign advance = !out_valid || out_ready;

   yolo_ctrl yolo_ctrl_inst (
      .clk         (clk),
      .rst         (rst),
      .start       (start),
      .cfg         (cfg),
      .in_valid    (in_valid),
      .advance     (advance),
      .last_elem   (last_elem),
      .last_item   (last_item),
      .pipe_busy   (pipe_busy),
      .out_pending (out_pending),
      .in_ready    (in_ready),
      .accept      (accept),
      .clear       (clear),
      .job         (job),
      .busy        (busy),
      .done        (done)
   );

   yolo_iter_cnt yolo_iter_cnt_inst (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .step       (accept),
      .len        (job.iterations),
      .items      (job.items),
      .first_elem (first_elem),
      .last_elem  (last_elem),
      .last_item  (last_item)
   );

   yolo_macc yolo_macc_inst (
      .clk        (clk),
      .rst        (rst),
      .advance    (advance),
      .accept     (accept),
      .first_elem (first_elem),
      .last_elem  (last_elem),
      .op         (in_data),
      .job        (job),
      .tok        (tok),
      .pipe_busy  (pipe_busy)
   );

   yolo_act_pool yolo_act_pool_inst (
      .clk         (clk),
      .rst         (rst),
      .advance     (advance),
      .tok         (tok),
      .job         (job),
      .out_valid   (out_valid),
      .out_ready   (out_ready),
      .out_data    (out_data),
      .out_pending (out_pending)
   );

endmodule

`default_nettype wire

/* yolo_layer_unit_chk.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_layer_unit_chk (
   input wire logic                    clk,
   input wire logic                    rst,
   input wire logic                    busy,
   input wire logic                    done,
   input wire logic                    in_ready,
   input wire logic                    out_valid,
   input wire logic                    out_ready,
   input wire logic [`YOLO_DATA_W-1:0] out_data
);
   timeunit 1ns;
   timeprecision 1ps;

   // a held output keeps its value
   hold_out: assert property (@(posedge clk) disable iff (rst)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("out_data changed while held");

   idle_no_ready: assert property (@(posedge clk) disable iff (rst) !busy |-> !in_ready)
      else $error("in_ready high outside a job");

   done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
      else $error("done longer than one cycle");

   // first cycle out of reset
   reset_quiet: assert property (@(posedge clk) $fell(rst) |-> !out_valid)
      else $error("out_valid high right after reset");

endmodule

`default_nettype wire

/* yolo_layer_unit_tb.sv */
`default_nettype none
`include "yolo_cfg.svh"

module yolo_layer_unit_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DW    = `YOLO_DATA_W;
   localparam int NROWS = 8;

   // one job of the table
   typedef struct packed {
      yolo_pkg::job_cfg_t cfg;
      logic               stall;
      logic               replay;
      logic               restart;
   } row_t;

   logic                 clk = 1'b0;
   logic                 rst;
   logic                 start;
   yolo_pkg::job_cfg_t   cfg;
   logic                 busy, done;
   logic                 in_valid, in_ready;
   yolo_pkg::operand_t   in_data;
   logic                 out_valid, out_ready;
   logic signed [DW-1:0] out_data;

   row_t                 rows [NROWS];
   yolo_pkg::operand_t   ops [$];
   logic signed [DW-1:0] exp_q [$];
   logic signed [DW-1:0] want;
   logic [31:0]          rng = 32'hdf1a;
   logic [31:0]          rdy_rng = 32'hdf1a;
   logic [31:0]          job_rng;
   logic                 stall_en = 1'b0;
   int                   errors = 0;
   int                   n_out = 0;
   int                   n_done = 0;
   int                   cycles = 0;
   int                   limit;

   yolo_layer_unit yolo_layer_unit_inst (.*);

   bind yolo_layer_unit yolo_layer_unit_chk yolo_layer_unit_chk_inst (.*);

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // flags are bias, leaky, maxpool, bypass; mode is stall, replay, restart
   function automatic row_t make_row(input int iter, input int items, input int shift,
                                     input logic [3:0] flags, input logic [2:0] mode);
      row_t r;
      r.cfg.iterations = `YOLO_ITER_W'(iter);
      r.cfg.items      = `YOLO_ITEM_W'(items);
      r.cfg.shift      = `YOLO_SHIFT_W'(shift);
      {r.cfg.bias_en, r.cfg.leaky_en, r.cfg.maxpool_en, r.cfg.bypass_en} = flags;
      {r.stall, r.replay, r.restart} = mode;
      return r;
   endfunction

   function automatic int elem_count(input yolo_pkg::job_cfg_t c);
      return c.bypass_en ? int'(c.items) : int'(c.iterations) * int'(c.items);
   endfunction

   // operands of one job and the outputs they should give
   task automatic build_job(input yolo_pkg::job_cfg_t c);
      logic signed [DW-1:0]   av, bv, v, pmax;
      logic signed [2*DW-1:0] sum, wide;
      yolo_pkg::operand_t     op;
      int                     i, j, base;
      ops.delete();
      for (i = 0; i < elem_count(c); i++) begin
         rng = xorshift(rng);
         op.a = DW'($signed(rng[7:0]));
         op.b = DW'($signed(rng[15:8]));
         op.c = DW'($signed(rng[23:16]));
         ops.push_back(op);
      end
      for (i = 0; i < c.items; i++) begin
         if (c.bypass_en) begin
            v = ops[i].a;
         end else begin
            base = i * c.iterations;
            av = ops[base].c;
            sum = '0;
            if (c.bias_en) begin
               sum = (2*DW)'(av) <<< c.shift;
            end
            for (j = 0; j < c.iterations; j++) begin
               av = ops[base + j].a;
               bv = ops[base + j].b;
               sum = sum + av * bv;
            end
            wide = sum >>> c.shift;
            v = wide[DW-1:0];
            if (c.leaky_en && v < 0) begin
               v = v >>> 3;
            end
         end
         if (!c.maxpool_en) begin
            exp_q.push_back(v);
         end else begin
            if (i % `YOLO_POOL_N == 0 || v > pmax) begin
               pmax = v;
            end
            if (i % `YOLO_POOL_N == `YOLO_POOL_N - 1) begin
               exp_q.push_back(pmax);
            end
         end
      end
   endtask

   task automatic run_job(input int r);
      row_t row;
      int   k, err0, out0, done0, n_exp;
      logic took;
      row = rows[r];
      // a replayed row streams the operands of the row before it
      if (row.replay) begin
         rng = job_rng;
      end
      job_rng = rng;
      build_job(row.cfg);
      n_exp = exp_q.size();
      err0 = errors;
      out0 = n_out;
      done0 = n_done;
      stall_en = row.stall;
      cfg = row.cfg;
      start = 1'b1;
      @(posedge clk);
      #2;
      start = 1'b0;
      if (busy !== 1'b1) begin
         $display("** Error: busy expected %h, got %h", 1'b1, busy);
         errors++;
      end
      for (k = 0; k < ops.size(); k++) begin
         in_valid = 1'b1;
         in_data = ops[k];
         // second start in the middle of the job
         if (row.restart && k == 1) begin
            cfg.items = `YOLO_ITEM_W'(1);
            start = 1'b1;
         end
         took = 1'b0;
         while (!took) begin
            @(negedge clk);
            took = in_ready;
            @(posedge clk);
            #2;
            start = 1'b0;
         end
      end
      in_valid = 1'b0;
      while (n_done == done0) begin
         @(posedge clk);
      end
      #2;
      if (busy !== 1'b0) begin
         $display("** Error: busy expected %h, got %h", 1'b0, busy);
         errors++;
      end
      if (exp_q.size() != 0) begin
         $display("job %0d: done came with %0d outputs missing", r, exp_q.size());
         errors++;
         exp_q.delete();
      end
      $display("job %0d: %0d of %0d outputs, %0d errors", r, n_out - out0, n_exp,
               errors - err0);
   endtask

   always @(posedge clk) begin
      #1;
      if (stall_en) begin
         rdy_rng = xorshift(rdy_rng);
         out_ready = rdy_rng[0];
      end else begin
         out_ready = 1'b1;
      end
   end

   // outputs and done are stable at the falling edge
   always @(negedge clk) begin
      if (!rst && out_valid && out_ready) begin
         if (exp_q.size() == 0) begin
            $display("output %h arrived when none was expected", out_data);
            errors++;
         end else begin
            want = exp_q.pop_front();
            n_out++;
            if (out_data !== want) begin
               $display("** Error: out_data expected %h, got %h", want, out_data);
               errors++;
            end
         end
      end
      if (!rst && done) begin
         n_done++;
      end
   end

   initial begin
      @(negedge rst);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: jobs did not finish within %0d cycles", limit);
      $display("Errors found");
      $finish;
   end

   initial begin
      int r;
      int total;
      rst = 1'b1;
      start = 1'b0;
      cfg = '0;
      in_valid = 1'b0;
      in_data = '0;
      out_ready = 1'b1;
      rows[0] = make_row(4, 6, 4, 4'b1000, 3'b000);
      rows[1] = make_row(5, 8, 3, 4'b1100, 3'b000);
      rows[2] = make_row(3, 8, 4, 4'b1110, 3'b000);
      rows[3] = make_row(1, 10, 0, 4'b0001, 3'b000);
      rows[4] = make_row(7, 12, 2, 4'b0011, 3'b000);
      rows[5] = make_row(4, 8, 4, 4'b1100, 3'b000);
      rows[6] = make_row(4, 8, 4, 4'b1100, 3'b110);
      rows[7] = make_row(2, 8, 5, 4'b1010, 3'b101);
      total = 0;
      for (r = 0; r < NROWS; r++) begin
         total += elem_count(rows[r].cfg);
      end
      limit = total * 8 + 200;
      repeat (4) @(posedge clk);
      #2;
      rst = 1'b0;
      for (r = 0; r < NROWS; r++) begin
         run_job(r);
      end
      if (n_done != NROWS) begin
         $display("saw %0d done pulses for %0d jobs", n_done, NROWS);
         errors++;
      end
      $display("%0d jobs, %0d outputs checked, %0d errors", NROWS, n_out, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
yolo_pkg.sv
yolo_iter_cnt.sv
yolo_ctrl.sv
yolo_macc.sv
yolo_act_pool.sv
yolo_layer_unit.sv
yolo_layer_unit_chk.sv
yolo_layer_unit_tb.sv

/* Bender.yml */
package:
  name: yolo_layer_unit

export_include_dirs:
  - .

sources:
  - files:
      - yolo_pkg.sv
      - yolo_iter_cnt.sv
      - yolo_ctrl.sv
      - yolo_macc.sv
      - yolo_act_pool.sv
      - yolo_layer_unit.sv
  - target: test
    files:
      - yolo_layer_unit_chk.sv
      - yolo_layer_unit_tb.sv
